/* fmaHalf_consts.svh */
`ifndef FMA_HALF_CONSTS_SVH
`define FMA_HALF_CONSTS_SVH

// binary16 field layout
`define HALF_EXP_W	5	// biased exponent field
`define HALF_MAN_W	10	// stored fraction
`define HALF_BIAS	15

//////////////////////////////
// datapath widths
//////////////////////////////

`define SIG_W		11	// fraction plus hidden one
`define PROD_W		22	// full significand product
`define SUM_W		36	// addend window plus product plus jam bit
`define EXP_INT_W	8	// signed internal exponent, covers both overflow and flush range

`endif

/* fmaFormatPkg.sv */
`default_nettype none

package fmaFormatPkg;

	// operand class after unpacking
	// subnormals land in clsZero
	typedef enum logic [2:0] {
		clsZero		= 3'd0,
		clsNormal	= 3'd1,
		clsInf		= 3'd2,
		clsQnan		= 3'd3,
		clsSnan		= 3'd4	// quiet bit clear, fraction nonzero
	} opClassT;

	// result decided up front in stage 1
	// anything but spNone bypasses the rounding datapath
	typedef enum logic [2:0] {
		spNone		= 3'd0,	// use adder result
		spInvalid	= 3'd1,	// snan in, 0*inf, inf-inf
		spQnan		= 3'd2,	// quiet nan propagation
		spInf		= 3'd3,	// signed infinity
		spZero		= 3'd4	// exact zero from zero operands
	} specialT;

endpackage

`default_nettype wire

/* fmaCtrlPkg.sv */
`default_nettype none

package fmaCtrlPkg;

	// rounding mode in risc-v frm encoding
	typedef enum logic [2:0] {
		rmRne	= 3'd0,	// nearest, ties to even
		rmRtz	= 3'd1,	// toward zero
		rmRdn	= 3'd2,	// toward -inf
		rmRup	= 3'd3,	// toward +inf
		rmRmm	= 3'd4	// nearest, ties away
	} roundModeT;

	// per-op exception flags, no divide by zero
	typedef struct packed {
		logic invalid;		// bit 3
		logic overflow;
		logic underflow;
		logic inexact;		// bit 0
	} fmaFlagsT;

endpackage

`default_nettype wire

/* fmaMulIf.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fmaHalf_consts.svh"

// stage 1 register contents, product plus aligned addend
interface fmaMulIf;
	import fmaFormatPkg::*;
	import fmaCtrlPkg::*;

	logic					valid;
	logic					productSign;
	logic [`PROD_W-1:0]			product;	// 2.20 fixed point
	logic [`SUM_W-1:0]			addend;		// aligned, bit 0 left clear for jam
	logic					addendSign;
	logic					addendSticky;	// OR of shifted-out addend bits
	logic					killProd;	// product reduced to a jam bit
	logic signed [`EXP_INT_W-1:0]		prodExp;	// biased exp of window bit PROD_W-1
	specialT				special;
	logic					specialSign;
	roundModeT				roundMode;

	modport mulSide (
		output valid, productSign, product, addend, addendSign, addendSticky,
		output killProd, prodExp, special, specialSign, roundMode
	);

	modport sumSide (
		input valid, productSign, product, addend, addendSign, addendSticky,
		input killProd, prodExp, special, specialSign, roundMode
	);

endinterface

`default_nettype wire

/* fmaNormIf.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fmaHalf_consts.svh"

// normalized magnitude going into the rounder
interface fmaNormIf;

	logic [`SIG_W+1:0]			normSig;	// 1.f, guard, round
	logic					sticky;
	logic					resultSign;
	logic signed [`EXP_INT_W-1:0]		resultExp;	// biased, unbounded
	logic					sumZero;	// exact cancellation

	modport normSide (
		output normSig, sticky, resultSign, resultExp, sumZero
	);

	modport roundSide (
		input normSig, sticky, resultSign, resultExp, sumZero
	);

endinterface

`default_nettype wire

/* fmaMulAlign.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fmaHalf_consts.svh"

module fmaMulAlign (
	input logic			clk,
	input logic			rstN,
	input logic			inValid,
	input logic [15:0]		opA,
	input logic [15:0]		opB,
	input logic [15:0]		opC,
	input fmaCtrlPkg::roundModeT	roundMode,
	fmaMulIf.mulSide		mul
);
	import fmaFormatPkg::*;
	import fmaCtrlPkg::*;

	localparam int alignOff = `SUM_W - `PROD_W - 1;	// addend msb slot above product 1.0
	localparam int maxShift = `SUM_W + 4;		// past this everything is sticky

	opClassT				clsA, clsB, clsC;
	logic [`HALF_EXP_W-1:0]			expA, expB, expC;
	logic [`SIG_W-1:0]			sigC;
	logic					signC, prodSign;
	logic					nanA, nanB;
	logic					prodZero, prodInf, cZero, anySnan, anyNan, isInvalid;
	logic [`PROD_W-1:0]			prodSig;
	logic signed [`EXP_INT_W-1:0]		prodExpRaw, shiftRaw, winExp;
	logic					kill;
	logic [5:0]				shiftAmt;
	logic [2*`SUM_W-1:0]			alignWide;
	specialT				spec;
	logic					specSign;

	function automatic opClassT classify(input logic [15:0] op);
		logic [`HALF_EXP_W-1:0] e;
		logic [`HALF_MAN_W-1:0] m;
		e = op[`HALF_MAN_W +: `HALF_EXP_W];
		m = op[`HALF_MAN_W-1:0];
		if (e == '0)
			classify = clsZero;	// subnormal flushed here
		else if (e != '1)
			classify = clsNormal;
		else if (m == '0)
			classify = clsInf;
		else if (m[`HALF_MAN_W-1])
			classify = clsQnan;
		else
			classify = clsSnan;
	endfunction

	//////////////////////////////
	// unpack and multiply
	//////////////////////////////

	assign clsA = classify(opA);
	assign clsB = classify(opB);
	assign clsC = classify(opC);
	assign expA = opA[`HALF_MAN_W +: `HALF_EXP_W];
	assign expB = opB[`HALF_MAN_W +: `HALF_EXP_W];
	assign expC = opC[`HALF_MAN_W +: `HALF_EXP_W];
	assign signC = opC[15];
	assign prodSign = opA[15] ^ opB[15];

	assign nanA = (clsA == clsQnan) || (clsA == clsSnan);
	assign nanB = (clsB == clsQnan) || (clsB == clsSnan);
	assign cZero = (clsC == clsZero);
	assign prodZero = (clsA == clsZero) || (clsB == clsZero);
	assign prodInf = ((clsA == clsInf) || (clsB == clsInf)) && !nanA && !nanB;

	// zero operand must not leave a stray jam bit
	assign prodSig = prodZero ? '0 :
		{1'b1, opA[`HALF_MAN_W-1:0]} * {1'b1, opB[`HALF_MAN_W-1:0]};
	assign sigC = cZero ? '0 : {1'b1, opC[`HALF_MAN_W-1:0]};

	//////////////////////////////
	// addend alignment
	//////////////////////////////

	assign prodExpRaw = `EXP_INT_W'(expA) + `EXP_INT_W'(expB) - `EXP_INT_W'(`HALF_BIAS);
	assign shiftRaw = prodExpRaw - `EXP_INT_W'(expC) + `EXP_INT_W'(alignOff);

	// addend too far above, or nothing to add to it
	assign kill = !cZero && (prodZero || (shiftRaw < 0));
	assign shiftAmt = kill ? 6'd0 : (shiftRaw > maxShift) ? 6'(maxShift) : shiftRaw[5:0];
	assign winExp = kill ? `EXP_INT_W'(expC) - `EXP_INT_W'(alignOff) : prodExpRaw;

	// sigC starts one below the window top, bits under window bit 1 go to sticky
	assign alignWide = {1'b0, sigC, {(2*`SUM_W-1-`SIG_W){1'b0}}} >> shiftAmt;

	//////////////////////////////
	// special results
	//////////////////////////////

	assign anySnan = (clsA == clsSnan) || (clsB == clsSnan) || (clsC == clsSnan);
	assign anyNan = nanA || nanB || (clsC == clsQnan) || anySnan;
	assign isInvalid = anySnan || (prodInf && prodZero) ||
		(prodInf && (clsC == clsInf) && (prodSign != signC));

	always_comb begin
		spec = spNone;
		specSign = 1'b0;
		if (isInvalid) begin
			spec = spInvalid;
		end else if (anyNan) begin
			spec = spQnan;
		end else if (prodInf) begin
			spec = spInf;
			specSign = prodSign;
		end else if (clsC == clsInf) begin
			spec = spInf;
			specSign = signC;
		end else if (prodZero && cZero) begin
			spec = spZero;	// unlike signs give +0, -0 only in rdn
			specSign = (prodSign == signC) ? signC : (roundMode == rmRdn);
		end
	end

	// stage boundary
	always_ff @(posedge clk) begin
		if (!rstN)
			mul.valid <= 1'b0;
		else
			mul.valid <= inValid;
	end

	always_ff @(posedge clk) begin
		if (inValid) begin
			mul.productSign <= prodSign;
			mul.product <= prodSig;
			mul.addend <= {alignWide[2*`SUM_W-1:`SUM_W+1], 1'b0};
			mul.addendSign <= signC;
			mul.addendSticky <= |alignWide[`SUM_W:0];
			mul.killProd <= kill;
			mul.prodExp <= winExp;
			mul.special <= spec;
			mul.specialSign <= specSign;
			mul.roundMode <= roundMode;
		end
	end

	// nothing can come out of the register on the first cycle out of reset
	assert property (@(posedge clk) $rose(rstN) |-> !mul.valid)
		else $error("fmaMulAlign: valid high right after reset release");

endmodule

`default_nettype wire

/* fmaAddNorm.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fmaHalf_consts.svh"

module fmaAddNorm (
	fmaMulIf.sumSide	mul,
	fmaNormIf.normSide	norm
);

	localparam int lzW = 6;

	logic [`SUM_W-1:0]	prodWin;	// product in window coordinates
	logic [`SUM_W-1:0]	addWin;		// aligned addend with jam bit
	logic [`SUM_W:0]	diff;		// extra bit catches a negative result
	logic [`SUM_W-1:0]	sumMag;
	logic [`SUM_W-1:0]	normWin;
	logic			effSub;
	logic			sumSign;
	logic [lzW-1:0]		lzCount;

	function automatic logic [lzW-1:0] countLz(input logic [`SUM_W-1:0] v);
		logic found;
		countLz = lzW'(`SUM_W);	// all zero
		found = 1'b0;
		for (int i = `SUM_W - 1; i >= 0; i--) begin
			if (v[i] && !found) begin
				countLz = lzW'(`SUM_W - 1 - i);
				found = 1'b1;
			end
		end
	endfunction

	//////////////////////////////
	// operand placement
	//////////////////////////////

	// product 1.0 sits on window bit PROD_W-1, bit 0 stays free
	// a killed product only survives as the jam bit
	assign prodWin = mul.killProd ?
		{{(`SUM_W-1){1'b0}}, |mul.product} :
		{{(`SUM_W-`PROD_W-1){1'b0}}, mul.product, 1'b0};

	// jam the sticky so a subtract borrows from it
	assign addWin = {mul.addend[`SUM_W-1:1], mul.addendSticky};

	assign effSub = mul.productSign ^ mul.addendSign;
	assign diff = {1'b0, prodWin} - {1'b0, addWin};

	always_comb begin
		if (!effSub) begin
			sumMag = prodWin + addWin;	// cannot carry out of the window
			sumSign = mul.productSign;
		end else if (diff[`SUM_W]) begin
			sumMag = ~diff[`SUM_W-1:0] + 1'b1;	// addend was larger
			sumSign = mul.addendSign;
		end else begin
			sumMag = diff[`SUM_W-1:0];
			sumSign = mul.productSign;
		end
	end

	//////////////////////////////
	// normalize
	//////////////////////////////

	assign lzCount = countLz(sumMag);
	assign normWin = sumMag << lzCount;	// msb lands on window top

	assign norm.normSig = normWin[`SUM_W-1 -: `SIG_W+2];
	assign norm.sticky = (|normWin[`SUM_W-`SIG_W-3:0]) | mul.addendSticky;
	assign norm.resultSign = sumSign;
	assign norm.sumZero = (sumMag == '0);

	// window top is SUM_W-PROD_W binades above the product reference bit
	assign norm.resultExp = mul.prodExp + `EXP_INT_W'(`SUM_W - `PROD_W) -
		`EXP_INT_W'(lzCount);

endmodule

`default_nettype wire

/* fmaRound.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fmaHalf_consts.svh"

module fmaRound (
	input logic			clk,
	input logic			rstN,
	fmaMulIf.sumSide		mul,
	fmaNormIf.roundSide		norm,
	output logic			outValid,
	output logic [15:0]		result,
	output fmaCtrlPkg::fmaFlagsT	flags
);
	import fmaFormatPkg::*;
	import fmaCtrlPkg::*;

	localparam logic [15:0] canonNan = 16'h7E00;
	localparam int expMax = (1 << `HALF_EXP_W) - 1;	// all ones, inf and nan

	logic [`SIG_W-1:0]		mant;
	logic				lsb, rndBit, stkBit, inexact, rndUp, ovfToInf;
	logic [`SIG_W:0]		rounded;	// one extra for the carry
	logic [`SIG_W-1:0]		mantOut;
	logic signed [`EXP_INT_W-1:0]	finalExp;
	logic [15:0]			resNext;
	fmaFlagsT			flagsNext;

	//////////////////////////////
	// round by mode
	//////////////////////////////

	assign mant = norm.normSig[`SIG_W+1:2];
	assign lsb = norm.normSig[2];
	assign rndBit = norm.normSig[1];
	assign stkBit = norm.normSig[0] | norm.sticky;
	assign inexact = rndBit | stkBit;

	always_comb begin
		case (mul.roundMode)
			rmRtz: rndUp = 1'b0;
			rmRdn: rndUp = norm.resultSign & inexact;
			rmRup: rndUp = ~norm.resultSign & inexact;
			rmRmm: rndUp = rndBit;
			default: rndUp = rndBit & (stkBit | lsb);	// rne
		endcase
	end

	assign rounded = {1'b0, mant} + (`SIG_W+1)'(rndUp);
	// carry out means 10.000, step the exponent
	assign mantOut = rounded[`SIG_W] ? rounded[`SIG_W:1] : rounded[`SIG_W-1:0];
	assign finalExp = norm.resultExp + `EXP_INT_W'(rounded[`SIG_W]);

	// overflow goes to inf unless the mode rounds toward zero for this sign
	always_comb begin
		case (mul.roundMode)
			rmRtz: ovfToInf = 1'b0;
			rmRdn: ovfToInf = norm.resultSign;
			rmRup: ovfToInf = ~norm.resultSign;
			default: ovfToInf = 1'b1;	// rne, rmm
		endcase
	end

	//////////////////////////////
	// result select
	//////////////////////////////

	always_comb begin
		flagsNext = '0;
		case (mul.special)
			spInvalid: begin
				resNext = canonNan;
				flagsNext.invalid = 1'b1;
			end
			spQnan: resNext = canonNan;	// quiet nan raises nothing
			spInf: resNext = {mul.specialSign, `HALF_EXP_W'(expMax), `HALF_MAN_W'(0)};
			spZero: resNext = {mul.specialSign, 15'd0};
			default: begin
				if (norm.sumZero) begin
					resNext = {mul.roundMode == rmRdn, 15'd0};	// exact cancel
				end else if (finalExp >= expMax) begin
					resNext = ovfToInf ?
						{norm.resultSign, `HALF_EXP_W'(expMax), `HALF_MAN_W'(0)} :
						{norm.resultSign, `HALF_EXP_W'(expMax - 1), {`HALF_MAN_W{1'b1}}};
					flagsNext.overflow = 1'b1;
					flagsNext.inexact = 1'b1;
				end else if (finalExp < 1) begin
					// tiny after rounding, flush
					resNext = {norm.resultSign, 15'd0};
					flagsNext.underflow = 1'b1;
					flagsNext.inexact = 1'b1;
				end else begin
					resNext = {norm.resultSign, finalExp[`HALF_EXP_W-1:0],
						mantOut[`HALF_MAN_W-1:0]};
					flagsNext.inexact = inexact;
				end
			end
		endcase
	end

	// stage 2 output register
	always_ff @(posedge clk) begin
		if (!rstN) begin
			outValid <= 1'b0;
			result <= '0;
			flags <= '0;
		end else begin
			outValid <= mul.valid;
			if (mul.valid) begin
				result <= resNext;
				flags <= flagsNext;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rstN)
		outValid && flags.overflow |-> flags.inexact)
		else $error("fmaRound: overflow without inexact");

	assert property (@(posedge clk) disable iff (!rstN)
		outValid && flags.invalid |-> result == canonNan)
		else $error("fmaRound: invalid with non-canonical result %h", result);

endmodule

`default_nettype wire

/* fmaUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module fmaUnit (
	input logic		clk,
	input logic		rstN,
	input logic		inValid,
	input logic [15:0]	opA,
	input logic [15:0]	opB,
	input logic [15:0]	opC,
	input logic [2:0]	roundMode,	// frm encoding
	output logic		outValid,
	output logic [15:0]	result,
	output logic [3:0]	flags		// invalid, overflow, underflow, inexact
);
	import fmaCtrlPkg::*;

	roundModeT	rmIn;
	fmaFlagsT	flagsOut;

	assign rmIn = roundModeT'(roundMode);
	assign flags = flagsOut;

	fmaMulIf	mulBus ();	// stage 1 register
	fmaNormIf	normBus ();	// stage 2 combinational path

	fmaMulAlign mulAlign (
		.clk		(clk),
		.rstN		(rstN),
		.inValid	(inValid),
		.opA		(opA),
		.opB		(opB),
		.opC		(opC),
		.roundMode	(rmIn),
		.mul		(mulBus.mulSide)
	);

	fmaAddNorm addNorm (
		.mul	(mulBus.sumSide),
		.norm	(normBus.normSide)
	);

	fmaRound round (
		.clk		(clk),
		.rstN		(rstN),
		.mul		(mulBus.sumSide),
		.norm		(normBus.roundSide),
		.outValid	(outValid),
		.result		(result),
		.flags		(flagsOut)
	);

endmodule

`default_nettype wire

/* fmaUnit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fmaUnit_tb;

	localparam int maxOps = 64;
	localparam int drainLimit = 20;	// cycles allowed for the last results

	logic		clk;
	logic		rstN;
	logic		inValid;
	logic [15:0]	opA;
	logic [15:0]	opB;
	logic [15:0]	opC;
	logic [2:0]	roundMode;
	logic		outValid;
	logic [15:0]	result;
	logic [3:0]	flags;

	// trace contents, one entry per operation
	int		gapMem [maxOps];
	logic [2:0]	rmMem [maxOps];
	logic [15:0]	aMem [maxOps];
	logic [15:0]	bMem [maxOps];
	logic [15:0]	cMem [maxOps];
	logic [15:0]	resMem [maxOps];
	logic [3:0]	flgMem [maxOps];
	int		numOps;

	// operations in flight
	logic [15:0]	expResQ [$];
	logic [3:0]	expFlgQ [$];
	int		issueQ [$];	// cycle the strobe is high in
	int		opIdxQ [$];

	int		cycle = 0;
	int		checked = 0;

	fmaUnit UUT (
		.clk		(clk),
		.rstN		(rstN),
		.inValid	(inValid),
		.opA		(opA),
		.opB		(opB),
		.opC		(opC),
		.roundMode	(roundMode),
		.outValid	(outValid),
		.result		(result),
		.flags		(flags)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;	// counts rising edges

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	//////////////////////////////
	// trace loading
	//////////////////////////////

	task automatic loadTrace();
		int fd;
		int n;
		string line;
		logic [31:0] gapV, rmV, aV, bV, cV, resV, flgV;
		fd = $fopen("fmaTrace.txt", "r");
		if (fd == 0)
			reportFailure("could not open the trace file fmaTrace.txt");
		numOps = 0;
		while (!$feof(fd) && numOps < maxOps) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() > 1 && line.getc(0) != "#") begin	// skip comments and blanks
				n = $sscanf(line, "%h %h %h %h %h %h %h", gapV, rmV, aV, bV, cV, resV, flgV);
				if (n != 7)
					reportFailure("a line of fmaTrace.txt does not hold seven fields");
				gapMem[numOps] = int'(gapV);
				rmMem[numOps] = rmV[2:0];
				aMem[numOps] = aV[15:0];
				bMem[numOps] = bV[15:0];
				cMem[numOps] = cV[15:0];
				resMem[numOps] = resV[15:0];
				flgMem[numOps] = flgV[3:0];
				numOps++;
			end
		end
		$fclose(fd);
	endtask

	//////////////////////////////
	// output checker
	//////////////////////////////

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		int idx;
		int expCycle;
		if (!rstN) begin
			assert (!outValid)
				else reportFailure("outValid went high while reset was asserted");
		end else if (outValid) begin
			assert (expResQ.size() > 0)
				else reportFailure("outValid went high with no operation pending");
			idx = opIdxQ.pop_front();
			expCycle = issueQ.pop_front() + 2;	// fixed two-cycle latency
			assert (cycle == expCycle)
				else reportFailure($sformatf("[ERROR] op %0d outValid cycle: expected %h, got %h",
					idx, expCycle, cycle));
			assert (result === expResQ[0])
				else reportFailure($sformatf("[ERROR] op %0d result: expected %h, got %h",
					idx, expResQ[0], result));
			assert (flags === expFlgQ[0])
				else reportFailure($sformatf("[ERROR] op %0d flags: expected %h, got %h",
					idx, expFlgQ[0], flags));
			void'(expResQ.pop_front());
			void'(expFlgQ.pop_front());
			checked++;
		end
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	initial begin
		int waitCycles;
		rstN = 1'b0;
		inValid = 1'b0;
		opA = '0;
		opB = '0;
		opC = '0;
		roundMode = '0;
		loadTrace();
		repeat (2) @(posedge clk);
		#1 rstN = 1'b1;

		for (int i = 0; i < numOps; i++) begin
			repeat (gapMem[i]) begin	// idle cycles before this strobe
				@(posedge clk);
				#1 inValid = 1'b0;
			end
			@(posedge clk);
			#1;
			inValid = 1'b1;
			opA = aMem[i];
			opB = bMem[i];
			opC = cMem[i];
			roundMode = rmMem[i];
			expResQ.push_back(resMem[i]);
			expFlgQ.push_back(flgMem[i]);
			issueQ.push_back(cycle);	// strobe cycle, sampled on the next edge
			opIdxQ.push_back(i);
		end
		@(posedge clk);
		#1 inValid = 1'b0;

		// drain with its own limit
		waitCycles = 0;
		while (expResQ.size() > 0 && waitCycles < drainLimit) begin
			@(posedge clk);
			waitCycles++;
		end
		repeat (3) @(posedge clk);	// stray strobes would show here

		if (expResQ.size() != 0 || checked != numOps) begin
			reportFailure("timeout: outputs stopped arriving before every operation completed");
		end else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* fmaTrace.txt */
# gap rm opA opB opC result flags, all hex; gap is idle cycles before the strobe
# rm: 0 rne 1 rtz 2 rdn 3 rup 4 rmm; flags: 8 invalid 4 overflow 2 underflow 1 inexact
2 0 3C00 3C00 3C00 4000 0
0 0 4000 4200 3C00 4700 0
0 0 3E00 3E00 B400 4000 0
1 1 4200 C000 3C00 C500 0
0 0 3C00 3C00 1000 3C00 1
0 1 3C00 3C00 1000 3C00 1
0 3 3C00 3C00 1000 3C01 1
0 4 3C00 3C00 1000 3C01 1
2 0 3C00 3C00 1200 3C01 1
0 1 3C00 3C00 1200 3C00 1
0 3 3C00 3C00 1200 3C01 1
1 0 3C00 3C00 0C00 3C00 1
0 4 3C00 3C00 0C00 3C00 1
0 0 3C01 3C00 1000 3C02 1
0 1 3C01 3C00 1000 3C01 1
3 2 BC00 3C00 9000 BC01 1
0 3 BC00 3C00 9000 BC00 1
0 0 3E00 4000 C200 0000 0
0 2 3E00 4000 C200 8000 0
1 0 3C00 3C00 7800 7800 1
0 3 3C00 3C00 7800 7801 1
0 1 3C00 BC00 7800 77FF 1
0 0 5800 5800 0400 7400 1
0 1 5800 5800 8400 73FF 1
2 0 7BFF 7BFF 0000 7C00 5
0 1 7BFF 7BFF 0000 7BFF 5
0 3 FBFF 7BFF 0000 FBFF 5
0 2 FBFF 7BFF 0000 FC00 5
0 3 3C00 7BFF 3C00 7C00 5
1 0 0400 0400 0000 0000 3
0 0 8400 0400 0000 8000 3
0 0 3C01 0400 8400 0000 3
0 0 0001 3C00 4000 4000 0
2 0 7C01 3C00 3C00 7E00 8
0 0 0000 7C00 3C00 7E00 8
0 0 7C00 3C00 FC00 7E00 8
0 0 3C00 7E12 3C00 7E00 0
0 0 7C00 C000 3C00 FC00 0

/* compile.f */
+incdir+.
fmaFormatPkg.sv
fmaCtrlPkg.sv
fmaMulIf.sv
fmaNormIf.sv
fmaMulAlign.sv
fmaAddNorm.sv
fmaRound.sv
fmaUnit.sv
fmaUnit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the fmaUnit testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	-f compile.f --top-module fmaUnit_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/VfmaUnit_tb 2>&1)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOut" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
